/* design/fetch_pkg.sv */
// Instruction fetch definitions
`default_nettype none

package fetch_pkg;

  //////////////////////////////////////////////////
  // widths with a meaning
  //////////////////////////////////////////////////

  // byte address on the fetch side
  typedef logic [31:0] addr_t;
  // full-length instruction word
  typedef logic [31:0] instr_t;
  // compressed half, low 16 bits of a fetched word
  typedef logic [15:0] cinstr_t;
  // interrupt cause, picks the vectored entry
  typedef logic [4:0]  irq_id_t;

  //////////////////////////////////////////////////
  // selectors and state
  //////////////////////////////////////////////////

  // source of the next fetch address
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // kind of trap vector
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,
    EXC_PC_IRQ     = 2'd1,
    EXC_PC_DBD     = 2'd2,
    EXC_PC_DBG_EXC = 2'd3
  } exc_pc_sel_e;

  // memory request FSM of the prefetch buffer
  typedef enum logic [1:0] {
    PF_IDLE        = 2'd0,
    PF_WAIT_GNT    = 2'd1,
    PF_WAIT_RVALID = 2'd2
  } pf_state_e;

  //////////////////////////////////////////////////
  // bundles
  //////////////////////////////////////////////////

  // one prefetched word with the address it came from
  typedef struct packed {
    instr_t rdata;
    addr_t  addr;
  } fetch_word_t;

  // IF-ID pipeline register contents
  typedef struct packed {
    instr_t  rdata;
    cinstr_t rdata_c;
    logic    is_compressed;
    logic    illegal_c;
    addr_t   pc;
    logic    new_instr;
    logic    valid;
  } id_instr_t;

  // debug module entry points
  localparam addr_t DmHaltAddr      = 32'h1A110800;
  localparam addr_t DmExceptionAddr = 32'h1A110808;

  // low byte of the reset PC inside the 256-byte boot region
  localparam logic [7:0] BootOffset = 8'h80;

  // prefetch queue entries
  localparam int unsigned PfDepth = 2;

endpackage

`default_nettype wire

/* design/fetch_pc_select.sv */
// Next fetch address selection
`default_nettype none

module fetch_pc_select (
  input  fetch_pkg::addr_t       boot_addr_i,
  input  fetch_pkg::pc_sel_e     pc_mux_i,
  input  fetch_pkg::exc_pc_sel_e exc_pc_mux_i,
  input  fetch_pkg::irq_id_t     irq_id_i,
  input  fetch_pkg::addr_t       jump_target_i,
  input  fetch_pkg::addr_t       csr_mepc_i,
  input  fetch_pkg::addr_t       csr_depc_i,
  output fetch_pkg::addr_t       fetch_addr_o,
  output fetch_pkg::addr_t       csr_mtvec_o
);

  fetch_pkg::addr_t exc_pc;

  // trap base is the 256-byte boot region, mode field reads as vectored
  assign csr_mtvec_o = {boot_addr_i[31:8], 6'b0, 2'b01};

  // trap vector
  always_comb begin
    unique case (exc_pc_mux_i)
      fetch_pkg::EXC_PC_EXC:     exc_pc = {boot_addr_i[31:8], 8'h00};
      // one word per cause
      fetch_pkg::EXC_PC_IRQ:     exc_pc = {boot_addr_i[31:8], 1'b0, irq_id_i, 2'b00};
      fetch_pkg::EXC_PC_DBD:     exc_pc = fetch_pkg::DmHaltAddr;
      fetch_pkg::EXC_PC_DBG_EXC: exc_pc = fetch_pkg::DmExceptionAddr;
      default:                   exc_pc = {boot_addr_i[31:8], 8'h00};
    endcase
  end

  // next fetch address
  always_comb begin
    unique case (pc_mux_i)
      fetch_pkg::PC_BOOT: fetch_addr_o = {boot_addr_i[31:8], fetch_pkg::BootOffset};
      fetch_pkg::PC_JUMP: fetch_addr_o = jump_target_i;
      fetch_pkg::PC_EXC:  fetch_addr_o = exc_pc;
      // return from trap
      fetch_pkg::PC_ERET: fetch_addr_o = csr_mepc_i;
      // return from debug mode
      fetch_pkg::PC_DRET: fetch_addr_o = csr_depc_i;
      default:            fetch_addr_o = jump_target_i;
    endcase
  end

endmodule

`default_nettype wire

/* design/fetch_prefetch_buffer.sv */
// Instruction prefetch buffer
`default_nettype none

module fetch_prefetch_buffer (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   req_i,
  input  logic                   branch_i,
  input  fetch_pkg::addr_t       branch_addr_i,
  input  logic                   ready_i,
  output logic                   valid_o,
  output fetch_pkg::fetch_word_t word_o,
  output logic                   instr_req_o,
  output fetch_pkg::addr_t       instr_addr_o,
  input  logic                   instr_gnt_i,
  input  logic                   instr_rvalid_i,
  input  fetch_pkg::instr_t      instr_rdata_i,
  output logic                   busy_o
);

  fetch_pkg::pf_state_e state_q, state_d;

  // next sequential word to request
  fetch_pkg::addr_t fetch_addr_q;
  // address held on the bus while waiting for grant
  fetch_pkg::addr_t req_addr_q;
  // address of the access in flight
  fetch_pkg::addr_t rsp_addr_q;

  // drop the next response, it belongs to a flushed stream
  logic discard_q, discard_d;

  logic issue_slot, issue, room, push, pop;

  fetch_pkg::fetch_word_t queue_q [fetch_pkg::PfDepth];
  logic [$clog2(fetch_pkg::PfDepth)-1:0] wr_ptr_q, rd_ptr_q;
  logic [$clog2(fetch_pkg::PfDepth):0]   cnt_q, cnt_d;

  //////////////////////////////////////////////////
  // queue occupancy
  //////////////////////////////////////////////////

  assign valid_o = (cnt_q != '0);
  assign word_o  = queue_q[rd_ptr_q];

  assign push = (state_q == fetch_pkg::PF_WAIT_RVALID) & instr_rvalid_i & ~discard_q & ~branch_i;
  assign pop  = ready_i & valid_o & ~branch_i;

  // count after this cycle, a branch empties the queue
  always_comb begin
    cnt_d = cnt_q;
    if (branch_i) begin
      cnt_d = '0;
    end else if (push && !pop) begin
      cnt_d = cnt_q + 1'b1;
    end else if (pop && !push) begin
      cnt_d = cnt_q - 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // memory request FSM
  //////////////////////////////////////////////////

  // a new access may start when nothing is outstanding after this cycle
  assign issue_slot = (state_q == fetch_pkg::PF_IDLE) |
                      ((state_q == fetch_pkg::PF_WAIT_RVALID) & instr_rvalid_i);
  // the returning word always needs a free slot
  assign room  = (cnt_d < fetch_pkg::PfDepth);
  assign issue = req_i & ~branch_i & issue_slot & room;

  // request stays up with a stable address until granted
  assign instr_req_o  = (state_q == fetch_pkg::PF_WAIT_GNT) | issue;
  assign instr_addr_o = (state_q == fetch_pkg::PF_WAIT_GNT) ? req_addr_q : fetch_addr_q;
  assign busy_o       = (state_q != fetch_pkg::PF_IDLE) | instr_req_o;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      fetch_pkg::PF_WAIT_GNT: begin
        if (instr_gnt_i) begin
          state_d = fetch_pkg::PF_WAIT_RVALID;
        end
      end
      fetch_pkg::PF_IDLE,
      fetch_pkg::PF_WAIT_RVALID: begin
        if (issue) begin
          state_d = instr_gnt_i ? fetch_pkg::PF_WAIT_RVALID : fetch_pkg::PF_WAIT_GNT;
        end else if (issue_slot) begin
          state_d = fetch_pkg::PF_IDLE;
        end
      end
      default: state_d = fetch_pkg::PF_IDLE;
    endcase
  end

  // a branch with an access pending or in flight marks its response stale
  always_comb begin
    discard_d = discard_q;
    if ((state_q == fetch_pkg::PF_WAIT_RVALID) && instr_rvalid_i) begin
      discard_d = 1'b0;
    end
    if (branch_i && ((state_q == fetch_pkg::PF_WAIT_GNT) ||
        ((state_q == fetch_pkg::PF_WAIT_RVALID) && !instr_rvalid_i))) begin
      discard_d = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= fetch_pkg::PF_IDLE;
      discard_q    <= 1'b0;
      fetch_addr_q <= '0;
      cnt_q        <= '0;
      wr_ptr_q     <= '0;
      rd_ptr_q     <= '0;
    end else begin
      state_q   <= state_d;
      discard_q <= discard_d;
      cnt_q     <= cnt_d;
      // word aligned restart on a branch
      if (branch_i) begin
        fetch_addr_q <= {branch_addr_i[31:2], 2'b00};
      end else if (instr_req_o && instr_gnt_i &&
                   !((state_q == fetch_pkg::PF_WAIT_GNT) && discard_q)) begin
        fetch_addr_q <= instr_addr_o + 32'd4;
      end
      if (branch_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
      end else begin
        if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
        if (pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  // addresses and queued words
  always_ff @(posedge clk_i) begin
    if (issue && !instr_gnt_i) begin
      req_addr_q <= fetch_addr_q;
    end
    if (instr_req_o && instr_gnt_i) begin
      rsp_addr_q <= instr_addr_o;
    end
    if (push) begin
      queue_q[wr_ptr_q] <= '{rdata: instr_rdata_i, addr: rsp_addr_q};
    end
  end

endmodule

`default_nettype wire

/* design/fetch_compressed_expander.sv */
// Compressed instruction expander
`default_nettype none

module fetch_compressed_expander (
  input  fetch_pkg::instr_t instr_i,
  output fetch_pkg::instr_t instr_o,
  output logic              is_compressed_o,
  output logic              illegal_o
);

  fetch_pkg::cinstr_t c;

  // only the low half matters for a compressed word
  assign c = instr_i[15:0];

  // low bits 11 mark a full-length word
  assign is_compressed_o = (instr_i[1:0] != 2'b11);

  always_comb begin
    instr_o   = '0;
    illegal_o = 1'b0;

    if (!is_compressed_o) begin
      instr_o = instr_i;
    end else begin
      // anything not matched below stays zero and illegal
      illegal_o = 1'b1;
      unique case ({c[1:0], c[15:13]})
        // c.addi -> addi rd, rd, imm
        5'b01_000: begin
          instr_o   = {{6{c[12]}}, c[12], c[6:2], c[11:7], 3'b000, c[11:7], 7'b0010011};
          illegal_o = 1'b0;
        end
        // c.li -> addi rd, x0, imm
        5'b01_010: begin
          instr_o   = {{6{c[12]}}, c[12], c[6:2], 5'd0, 3'b000, c[11:7], 7'b0010011};
          illegal_o = 1'b0;
        end
        // c.j -> jal x0, offset
        5'b01_101: begin
          instr_o   = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                       c[12], {8{c[12]}}, 5'd0, 7'b1101111};
          illegal_o = 1'b0;
        end
        // c.lwsp -> lw rd, offset(x2)
        5'b10_010: begin
          // rd of zero is reserved
          if (c[11:7] != 5'd0) begin
            instr_o   = {4'b0, c[3:2], c[12], c[6:4], 2'b00, 5'd2, 3'b010, c[11:7],
                         7'b0000011};
            illegal_o = 1'b0;
          end
        end
        // c.mv and c.add, rs2 of zero would be the jump forms
        5'b10_100: begin
          if (c[6:2] != 5'd0) begin
            if (c[12]) begin
              instr_o = {7'b0, c[6:2], c[11:7], 3'b000, c[11:7], 7'b0110011};
            end else begin
              instr_o = {7'b0, c[6:2], 5'd0, 3'b000, c[11:7], 7'b0110011};
            end
            illegal_o = 1'b0;
          end
        end
        default: begin
          instr_o = '0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/fetch_if_stage.sv */
// Instruction fetch stage top
`default_nettype none

module fetch_if_stage (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  fetch_pkg::addr_t       boot_addr_i,
  input  logic                   req_i,
  input  logic                   pc_set_i,
  input  fetch_pkg::pc_sel_e     pc_mux_i,
  input  fetch_pkg::exc_pc_sel_e exc_pc_mux_i,
  input  fetch_pkg::irq_id_t     irq_id_i,
  input  fetch_pkg::addr_t       jump_target_i,
  input  fetch_pkg::addr_t       csr_mepc_i,
  input  fetch_pkg::addr_t       csr_depc_i,
  // instruction memory
  output logic                   instr_req_o,
  output fetch_pkg::addr_t       instr_addr_o,
  input  logic                   instr_gnt_i,
  input  logic                   instr_rvalid_i,
  input  fetch_pkg::instr_t      instr_rdata_i,
  // decode side
  input  logic                   id_in_ready_i,
  input  logic                   instr_valid_clear_i,
  output logic                   if_id_we_o,
  output fetch_pkg::id_instr_t   id_instr_o,
  // status
  output fetch_pkg::addr_t       pc_if_o,
  output fetch_pkg::addr_t       csr_mtvec_o,
  output logic                   if_busy_o,
  output logic                   perf_imiss_o
);

  fetch_pkg::addr_t       fetch_addr_n;
  fetch_pkg::fetch_word_t fetch_word;
  fetch_pkg::instr_t      instr_expanded;
  logic                   fetch_valid, branch_req, init_q;
  logic                   is_compressed, illegal_c;

  // IF-ID register, flags and payload
  logic                   id_valid_q, id_new_q, id_is_c_q, id_illegal_q;
  fetch_pkg::instr_t      id_rdata_q;
  fetch_pkg::cinstr_t     id_rdata_c_q;
  fetch_pkg::addr_t       id_pc_q;

  fetch_pc_select i_fetch_pc_select (
    .boot_addr_i  (boot_addr_i),
    .pc_mux_i     (pc_mux_i),
    .exc_pc_mux_i (exc_pc_mux_i),
    .irq_id_i     (irq_id_i),
    .jump_target_i(jump_target_i),
    .csr_mepc_i   (csr_mepc_i),
    .csr_depc_i   (csr_depc_i),
    .fetch_addr_o (fetch_addr_n),
    .csr_mtvec_o  (csr_mtvec_o)
  );

  //////////////////////////////////////////////////
  // branch control
  //////////////////////////////////////////////////

  // first request after reset or any pc_set_i restarts the stream
  assign branch_req = (init_q & req_i) | pc_set_i;
  // a word moves to decode only when no redirect is under way
  assign if_id_we_o = fetch_valid & ~branch_req & req_i & id_in_ready_i;

  assign pc_if_o      = fetch_word.addr;
  assign perf_imiss_o = ~fetch_valid | branch_req;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      init_q <= 1'b1;
    end else if (branch_req) begin
      init_q <= 1'b0;
    end
  end

  fetch_prefetch_buffer i_fetch_prefetch_buffer (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .branch_i      (branch_req),
    .branch_addr_i ({fetch_addr_n[31:1], 1'b0}),
    .ready_i       (if_id_we_o),
    .valid_o       (fetch_valid),
    .word_o        (fetch_word),
    .instr_req_o   (instr_req_o),
    .instr_addr_o  (instr_addr_o),
    .instr_gnt_i   (instr_gnt_i),
    .instr_rvalid_i(instr_rvalid_i),
    .instr_rdata_i (instr_rdata_i),
    .busy_o        (if_busy_o)
  );

  fetch_compressed_expander i_fetch_compressed_expander (
    .instr_i        (fetch_word.rdata),
    .instr_o        (instr_expanded),
    .is_compressed_o(is_compressed),
    .illegal_o      (illegal_c)
  );

  //////////////////////////////////////////////////
  // IF-ID pipeline register
  //////////////////////////////////////////////////

  // new pulses after a write, valid holds until cleared
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_new_q   <= 1'b0;
      id_valid_q <= 1'b0;
    end else begin
      id_new_q <= if_id_we_o;
      if (if_id_we_o) begin
        id_valid_q <= 1'b1;
      end else if (instr_valid_clear_i) begin
        id_valid_q <= 1'b0;
      end
    end
  end

  // frozen while decode stalls
  always_ff @(posedge clk_i) begin
    if (if_id_we_o) begin
      id_rdata_q   <= instr_expanded;
      id_rdata_c_q <= fetch_word.rdata[15:0];
      id_is_c_q    <= is_compressed;
      id_illegal_q <= illegal_c;
      id_pc_q      <= fetch_word.addr;
    end
  end

  assign id_instr_o = '{rdata:         id_rdata_q,
                        rdata_c:       id_rdata_c_q,
                        is_compressed: id_is_c_q,
                        illegal_c:     id_illegal_q,
                        pc:            id_pc_q,
                        new_instr:     id_new_q,
                        valid:         id_valid_q};

endmodule

`default_nettype wire

/* sim/fetch_properties.sv */
// Fetch memory port properties
`default_nettype none

module fetch_properties (
  input logic             clk_i,
  input logic             rst_ni,
  input fetch_pkg::addr_t boot_addr_i,
  input logic             instr_req_o,
  input fetch_pkg::addr_t instr_addr_o,
  input logic             instr_gnt_i
);

  // grant only answers a pending request
  gnt_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_gnt_i |-> instr_req_o)
    else $error("instruction grant without a request");

  // fetch is word granular
  addr_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o |-> (instr_addr_o[1:0] == 2'b00))
    else $error("instruction address not word aligned");

  // boot region starts on a 256-byte boundary
  boot_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    boot_addr_i[7:0] == 8'h00)
    else $error("boot address low byte not zero");

  // request and address held until granted
  addr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (instr_req_o && !instr_gnt_i) |=> (instr_req_o && $stable(instr_addr_o)))
    else $error("request dropped or address changed before grant");

endmodule

bind fetch_if_stage fetch_properties i_fetch_properties (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .boot_addr_i (boot_addr_i),
  .instr_req_o (instr_req_o),
  .instr_addr_o(instr_addr_o),
  .instr_gnt_i (instr_gnt_i)
);

`default_nettype wire

/* sim/fetch_tb.sv */
// Fetch stage testbench
`default_nettype none

module fetch_tb;

  logic                   clk_i, rst_ni, req_i, pc_set_i;
  fetch_pkg::addr_t       boot_addr_i, jump_target_i, csr_mepc_i, csr_depc_i;
  fetch_pkg::pc_sel_e     pc_mux_i;
  fetch_pkg::exc_pc_sel_e exc_pc_mux_i;
  fetch_pkg::irq_id_t     irq_id_i;
  logic                   instr_req_o, instr_gnt_i, instr_rvalid_i;
  fetch_pkg::addr_t       instr_addr_o, pc_if_o, csr_mtvec_o;
  fetch_pkg::instr_t      instr_rdata_i;
  logic                   id_in_ready_i, instr_valid_clear_i, if_id_we_o;
  fetch_pkg::id_instr_t   id_instr_o;
  logic                   if_busy_o, perf_imiss_o;

  // memory image and test records from the stimulus file
  fetch_pkg::instr_t mem [fetch_pkg::addr_t];
  string             test_name [$];
  string             test_kind [$];
  fetch_pkg::addr_t  test_addr [$];
  int                test_count [$];
  fetch_pkg::addr_t  exp_pc [$];
  fetch_pkg::instr_t exp_instr [$];
  logic              exp_c [$];
  logic              exp_ill [$];

  int          errors, test_errors, failed_tests;
  int unsigned wait_limit;
  bit          timed_out, started, have_snap;
  logic [81:0] snap;
  logic [31:0] rng;
  // separate stream for the decode ready pattern
  logic [31:0] ready_rng;

  // write strobe and head PC, read one edge later by the delivery checks
  logic             we_last;
  fetch_pkg::addr_t pc_last;

  // memory model state
  logic             req_s, hs_s, gnt_busy, rsp_busy;
  fetch_pkg::addr_t addr_s, rsp_addr;
  int               gnt_wait, rsp_wait;

  fetch_if_stage i_fetch_if_stage (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .boot_addr_i        (boot_addr_i),
    .req_i              (req_i),
    .pc_set_i           (pc_set_i),
    .pc_mux_i           (pc_mux_i),
    .exc_pc_mux_i       (exc_pc_mux_i),
    .irq_id_i           (irq_id_i),
    .jump_target_i      (jump_target_i),
    .csr_mepc_i         (csr_mepc_i),
    .csr_depc_i         (csr_depc_i),
    .instr_req_o        (instr_req_o),
    .instr_addr_o       (instr_addr_o),
    .instr_gnt_i        (instr_gnt_i),
    .instr_rvalid_i     (instr_rvalid_i),
    .instr_rdata_i      (instr_rdata_i),
    .id_in_ready_i      (id_in_ready_i),
    .instr_valid_clear_i(instr_valid_clear_i),
    .if_id_we_o         (if_id_we_o),
    .id_instr_o         (id_instr_o),
    .pc_if_o            (pc_if_o),
    .csr_mtvec_o        (csr_mtvec_o),
    .if_busy_o          (if_busy_o),
    .perf_imiss_o       (perf_imiss_o)
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #50 clk_i = ~clk_i;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // unmapped words get a pattern of the full address, low bits end up 11
  function automatic fetch_pkg::instr_t mem_read(input fetch_pkg::addr_t a);
    if (mem.exists(a)) return mem[a];
    return a ^ 32'h5a5a_0003;
  endfunction

  // IF-ID fields that may only change on a write
  function automatic logic [81:0] frozen_fields(input fetch_pkg::id_instr_t x);
    return {x.rdata, x.rdata_c, x.is_compressed, x.illegal_c, x.pc};
  endfunction

  //////////////////////////////////////////////////
  // instruction memory with random gnt and rvalid delay
  //////////////////////////////////////////////////

  // port state as seen at the coming rising edge
  always @(negedge clk_i) begin
    req_s  = instr_req_o;
    addr_s = instr_addr_o;
    hs_s   = instr_req_o & instr_gnt_i;
  end

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      instr_gnt_i    <= 1'b0;
      instr_rvalid_i <= 1'b0;
      gnt_busy = 1'b0;
      rsp_busy = 1'b0;
    end else begin
      instr_gnt_i    <= 1'b0;
      instr_rvalid_i <= 1'b0;
      if (rsp_busy) begin
        if (rsp_wait == 0) begin
          instr_rvalid_i <= 1'b1;
          instr_rdata_i  <= mem_read(rsp_addr);
          rsp_busy = 1'b0;
        end else begin
          rsp_wait--;
        end
      end
      // granted at this edge, response follows 1 to 4 cycles later
      if (hs_s) begin
        gnt_busy = 1'b0;
        rsp_busy = 1'b1;
        rsp_addr = addr_s;
        rng = xorshift32(rng);
        rsp_wait = rng[1:0];
      end else if (req_s) begin
        if (!gnt_busy) begin
          gnt_busy = 1'b1;
          rng = xorshift32(rng);
          gnt_wait = rng[1:0];
        end
        if (gnt_wait == 0) begin
          instr_gnt_i <= 1'b1;
        end else begin
          gnt_wait--;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // status monitor
  //////////////////////////////////////////////////

  always @(negedge clk_i) begin
    we_last <= if_id_we_o;
    pc_last <= pc_if_o;
    if (rst_ni) begin
      // busy while a request waits or a response is still due
      check_cond(if_busy_o == (instr_req_o | rsp_busy | instr_rvalid_i),
                 $sformatf("if_busy_o is %b, expected %b", if_busy_o,
                           instr_req_o | rsp_busy | instr_rvalid_i));
      if (!id_in_ready_i || !req_i) begin
        check_cond(!if_id_we_o, "if_id_we_o high while decode is not ready");
      end
    end
  end

  //////////////////////////////////////////////////
  // stimulus, collection and checks
  //////////////////////////////////////////////////

  task automatic check_cond(input logic cond, input string msg);
    assert (cond) else begin
      $display("FAIL %0t: %s", $time, msg);
      errors++;
      test_errors++;
    end
  endtask

  task automatic load_stimulus();
    int          fd, n, cnt;
    string       tok, line, name, kind;
    logic [31:0] a, w, c, il;
    fd = $fopen("sim/fetch_stimulus.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file sim/fetch_stimulus.txt");
      errors++;
      return;
    end
    while ($fscanf(fd, "%s", tok) == 1) begin
      if (tok == "#") begin
        n = $fgets(line, fd);
      end else if (tok == "M") begin
        n = $fscanf(fd, "%h %h", a, w);
        mem[a] = w;
      end else if (tok == "T") begin
        n = $fscanf(fd, "%s %s %h %d", name, kind, a, cnt);
        test_name.push_back(name);
        test_kind.push_back(kind);
        test_addr.push_back(a);
        test_count.push_back(cnt);
      end else if (tok == "E") begin
        n = $fscanf(fd, "%h %h %h %h", a, w, c, il);
        exp_pc.push_back(a);
        exp_instr.push_back(w);
        exp_c.push_back(c[0]);
        exp_ill.push_back(il[0]);
      end
    end
    $fclose(fd);
  endtask

  // first redirect comes from req_i in init, later ones from pc_set_i
  task automatic redirect(input string kind, input fetch_pkg::addr_t addr);
    @(posedge clk_i);
    id_in_ready_i <= 1'b1;
    req_i         <= 1'b1;
    pc_set_i      <= started;
    started = 1'b1;
    if (kind == "boot") begin
      pc_mux_i <= fetch_pkg::PC_BOOT;
    end else if (kind == "irq") begin
      pc_mux_i     <= fetch_pkg::PC_EXC;
      exc_pc_mux_i <= fetch_pkg::EXC_PC_IRQ;
      irq_id_i     <= addr[4:0];
    end else if (kind == "dbg") begin
      pc_mux_i     <= fetch_pkg::PC_EXC;
      exc_pc_mux_i <= fetch_pkg::EXC_PC_DBD;
    end else begin
      pc_mux_i      <= fetch_pkg::PC_JUMP;
      jump_target_i <= addr;
    end
    @(negedge clk_i);
    // branch strobe is up in this cycle
    check_cond(perf_imiss_o && !if_id_we_o, "perf_imiss_o low or a write in the branch cycle");
    @(posedge clk_i);
    pc_set_i <= 1'b0;
    @(negedge clk_i);
    // queue flushed, nothing written
    check_cond(perf_imiss_o && !id_instr_o.new_instr,
               "perf_imiss_o low or new_instr high right after the branch");
  endtask

  // one cycle per pass, register must hold between writes
  task automatic wait_for_new_instr(input bit random_ready, output bit ok);
    int unsigned waited;
    waited = 0;
    ok = 1'b0;
    while (!ok && waited < wait_limit) begin
      @(posedge clk_i);
      if (random_ready) begin
        ready_rng = xorshift32(ready_rng);
        id_in_ready_i <= ready_rng[0];
      end
      @(negedge clk_i);
      if (id_instr_o.new_instr) begin
        ok = 1'b1;
        check_cond(we_last, "new_instr without if_id_we_o in the cycle before");
      end else begin
        waited++;
        check_cond(!we_last, "if_id_we_o high but no new_instr followed");
        if (have_snap) begin
          check_cond(frozen_fields(id_instr_o) == snap, "IF-ID register changed without a write");
        end
      end
    end
    if (!ok) begin
      $display("timed out waiting for instruction");
      timed_out = 1'b1;
    end
  endtask

  task automatic collect(input int first, input int count, input bit random_ready);
    int                k;
    bit                ok;
    fetch_pkg::instr_t word;
    have_snap = 1'b0;
    for (k = first; k < first + count; k++) begin
      wait_for_new_instr(random_ready, ok);
      if (!ok) return;
      word = mem_read(exp_pc[k]);
      check_cond(id_instr_o.pc == exp_pc[k],
                 $sformatf("pc %h, expected %h", id_instr_o.pc, exp_pc[k]));
      check_cond(pc_last == exp_pc[k],
                 $sformatf("pc_if_o %h during the write, expected %h", pc_last, exp_pc[k]));
      check_cond(id_instr_o.rdata == exp_instr[k],
                 $sformatf("instruction at %h is %h, expected %h",
                           exp_pc[k], id_instr_o.rdata, exp_instr[k]));
      check_cond(id_instr_o.is_compressed == exp_c[k],
                 $sformatf("compressed flag at %h is %b", exp_pc[k], id_instr_o.is_compressed));
      check_cond(id_instr_o.illegal_c == exp_ill[k],
                 $sformatf("illegal flag at %h is %b", exp_pc[k], id_instr_o.illegal_c));
      check_cond(id_instr_o.rdata_c == word[15:0],
                 $sformatf("low half at %h is %h, expected %h",
                           exp_pc[k], id_instr_o.rdata_c, word[15:0]));
      check_cond(id_instr_o.valid == 1'b1, "valid is low on a new instruction");
      snap = frozen_fields(id_instr_o);
      have_snap = 1'b1;
    end
  endtask

  // clear without a write, then the next delivery restores valid
  task automatic valid_clear_check();
    bit ok;
    @(posedge clk_i);
    id_in_ready_i       <= 1'b0;
    instr_valid_clear_i <= 1'b1;
    @(posedge clk_i);
    instr_valid_clear_i <= 1'b0;
    @(negedge clk_i);
    check_cond(id_instr_o.valid == 1'b0, "valid stays high after instr_valid_clear_i");
    have_snap = 1'b0;
    @(posedge clk_i);
    id_in_ready_i <= 1'b1;
    wait_for_new_instr(1'b0, ok);
    if (ok) begin
      check_cond(id_instr_o.valid == 1'b1, "valid stays low after a new delivery");
    end
  endtask

  initial begin
    int t, first;
    errors = 0;
    failed_tests = 0;
    timed_out = 1'b0;
    started = 1'b0;
    have_snap = 1'b0;
    wait_limit = 200;
    rng = 32'h90a0;
    ready_rng = 32'h90a0;
    rst_ni = 1'b0;
    req_i = 1'b0;
    pc_set_i = 1'b0;
    boot_addr_i = 32'h0000_1000;
    pc_mux_i = fetch_pkg::PC_BOOT;
    exc_pc_mux_i = fetch_pkg::EXC_PC_EXC;
    irq_id_i = '0;
    jump_target_i = '0;
    csr_mepc_i = '0;
    csr_depc_i = '0;
    instr_gnt_i = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i = '0;
    id_in_ready_i = 1'b1;
    instr_valid_clear_i = 1'b0;
    load_stimulus();
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_cond(!instr_req_o && !if_id_we_o && !id_instr_o.valid && !id_instr_o.new_instr,
               "memory request, write or valid flag up after reset");
    first = 0;
    for (t = 0; t < test_name.size() && !timed_out; t++) begin
      test_errors = 0;
      redirect(test_kind[t], test_addr[t]);
      if (test_kind[t] == "irq") begin
        check_cond(csr_mtvec_o == {boot_addr_i[31:8], 8'h01},
                   $sformatf("csr_mtvec_o is %h, expected base with mode 01", csr_mtvec_o));
      end
      collect(first, test_count[t], test_kind[t] == "bp");
      if (test_kind[t] == "clr" && !timed_out) begin
        valid_clear_check();
      end
      first += test_count[t];
      if (test_errors == 0 && !timed_out) begin
        $display("test %s: passed", test_name[t]);
      end else begin
        $display("test %s: failed, %0d check errors", test_name[t], test_errors);
        failed_tests++;
      end
    end
    $display("tests run %0d, tests failed %0d, check errors %0d", t, failed_tests, errors);
    if (errors == 0 && !timed_out && test_name.size() != 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim/fetch_stimulus.txt */
# M address word : instruction memory image, hex
# T name kind address count : redirect kind and address, then count E records
# E pc instruction compressed illegal : expected IF-ID contents in delivery order
M 00001080 00100093
M 00001084 00208113
M 00001088 00310193
T boot_sequence boot 00000000 3
E 00001080 00100093 0 0
E 00001084 00208113 0 0
E 00001088 00310193 0 0
M 00002000 beef0085
M 00002004 0000517d
M 00002008 00008192
M 0000200c 0000929a
M 00002010 00004422
M 00002014 0000a011
M 00002018 12340000
T compressed_expansion jump 00002000 7
E 00002000 00108093 1 0
E 00002004 fff00113 1 0
E 00002008 004001b3 1 0
E 0000200c 006282b3 1 0
E 00002010 00812403 1 0
E 00002014 0040006f 1 0
E 00002018 00000000 1 1
M 00003000 00a00513
M 00003004 00b00593
T jump_redirect jump 00003000 2
E 00003000 00a00513 0 0
E 00003004 00b00593 0 0
M 00001014 30200073
T irq_vector irq 00000005 1
E 00001014 30200073 0 0
M 1a110800 00100073
T debug_halt dbg 00000000 1
E 1a110800 00100073 0 0
T back_pressure bp 00001080 3
E 00001080 00100093 0 0
E 00001084 00208113 0 0
E 00001088 00310193 0 0
T valid_clear clr 00003000 2
E 00003000 00a00513 0 0
E 00003004 00b00593 0 0

/* sim.f */
design/fetch_pkg.sv
design/fetch_pc_select.sv
design/fetch_prefetch_buffer.sv
design/fetch_compressed_expander.sv
design/fetch_if_stage.sv
sim/fetch_properties.sv
sim/fetch_tb.sv

/* Bender.yml */
package:
  name: fetch_stage

sources:
  - files:
      - design/fetch_pkg.sv
      - design/fetch_pc_select.sv
      - design/fetch_prefetch_buffer.sv
      - design/fetch_compressed_expander.sv
      - design/fetch_if_stage.sv
  - target: test
    files:
      - sim/fetch_properties.sv
      - sim/fetch_tb.sv
